// File: flist.f
tgen_pkg.sv
tgen_config_regs.sv
tgen_tx_fsm.sv
tgen_rx_analyzer.sv
tgen_switch_stamp.sv
simple_tx.sv
tb_simple_tx.sv

// File: simple_tx.sv
`timescale 1ns/1ps

module simple_tx (
  input  logic                S_AXI_ACLK,
  input  logic                S_AXI_ARESETN,
  // configuration
  input  tgen_pkg::word_t     cfg_ipg,
  input  tgen_pkg::word_t     cfg_frame_count,
  input  tgen_pkg::word_t     cfg_word_count,
  input  tgen_pkg::word_t     cfg_last_strb,
  // gate and counter reset
  input  logic                ext_gate_ctrl,
  input  logic                ext_rst_count,
  // switch events, single cycle pulses
  input  logic                ext_switch_lane0_on,
  input  logic                ext_switch_lane1_on,
  input  logic                ext_switch_lane0_done,
  input  logic                ext_switch_lane1_done,
  input  tgen_pkg::stamp_t    stamp_counter,
  // master stream
  output tgen_pkg::tdata_t    m_axis_tdata,
  output tgen_pkg::tstrb_t    m_axis_tstrb,
  output tgen_pkg::tuser_t    m_axis_tuser,
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output logic                m_axis_tlast,
  // slave stream
  input  tgen_pkg::tdata_t    s_axis_tdata,
  input  logic                s_axis_tvalid,
  input  logic                s_axis_tlast,
  output logic                s_axis_tready,
  // results
  output tgen_pkg::word_t     arr_seq_num,
  output tgen_pkg::word_t     exp_seq_num,
  output tgen_pkg::stamp_t    rx_stamp_start,
  output tgen_pkg::stamp_t    rx_stamp_stop,
  output tgen_pkg::sw_stamp_t sw_ln0_start,
  output tgen_pkg::sw_stamp_t sw_ln0_stop,
  output tgen_pkg::sw_stamp_t sw_ln1_start,
  output tgen_pkg::sw_stamp_t sw_ln1_stop
);

  // registered configuration
  tgen_pkg::word_t ipg_value;
  tgen_pkg::word_t frame_value;
  tgen_pkg::word_t words_value;
  tgen_pkg::word_t last_strb_value;
  logic            gate_pulse;
  // synchronous clear for every statistic
  logic            cnt_rst;

  ////////////////////////////////////////
  // config
  ////////////////////////////////////////

  tgen_config_regs u_config_regs (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .cfg_ipg         (cfg_ipg),
    .cfg_frame_count (cfg_frame_count),
    .cfg_word_count  (cfg_word_count),
    .cfg_last_strb   (cfg_last_strb),
    .ext_gate_ctrl   (ext_gate_ctrl),
    .ext_rst_count   (ext_rst_count),
    .ipg_value       (ipg_value),
    .frame_value     (frame_value),
    .words_value     (words_value),
    .last_strb_value (last_strb_value),
    .gate_pulse      (gate_pulse),
    .cnt_rst         (cnt_rst)
  );

  ////////////////////////////////////////
  // tx generator
  ////////////////////////////////////////

  tgen_tx_fsm u_tx_fsm (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .cnt_rst         (cnt_rst),
    .gate_pulse      (gate_pulse),
    .ipg_value       (ipg_value),
    .frame_value     (frame_value),
    .words_value     (words_value),
    .last_strb_value (last_strb_value),
    .stamp_counter   (stamp_counter),
    .m_axis_tdata    (m_axis_tdata),
    .m_axis_tstrb    (m_axis_tstrb),
    .m_axis_tuser    (m_axis_tuser),
    .m_axis_tvalid   (m_axis_tvalid),
    .m_axis_tready   (m_axis_tready),
    .m_axis_tlast    (m_axis_tlast)
  );

  ////////////////////////////////////////
  // rx analyzer and switch stamps
  ////////////////////////////////////////

  tgen_rx_analyzer u_rx_analyzer (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .cnt_rst        (cnt_rst),
    .s_axis_tdata   (s_axis_tdata),
    .s_axis_tvalid  (s_axis_tvalid),
    .s_axis_tlast   (s_axis_tlast),
    .stamp_counter  (stamp_counter),
    .s_axis_tready  (s_axis_tready),
    .arr_seq_num    (arr_seq_num),
    .exp_seq_num    (exp_seq_num),
    .rx_stamp_start (rx_stamp_start),
    .rx_stamp_stop  (rx_stamp_stop)
  );

  tgen_switch_stamp u_switch_stamp (
    .S_AXI_ACLK            (S_AXI_ACLK),
    .cnt_rst               (cnt_rst),
    .ext_switch_lane0_on   (ext_switch_lane0_on),
    .ext_switch_lane1_on   (ext_switch_lane1_on),
    .ext_switch_lane0_done (ext_switch_lane0_done),
    .ext_switch_lane1_done (ext_switch_lane1_done),
    .stamp_counter         (stamp_counter),
    .sw_ln0_start          (sw_ln0_start),
    .sw_ln0_stop           (sw_ln0_stop),
    .sw_ln1_start          (sw_ln1_start),
    .sw_ln1_stop           (sw_ln1_stop)
  );

endmodule

// File: tb_simple_tx.sv
`timescale 1ns/1ps

module tb_simple_tx;

  // columns per line of tgen_testdata.txt
  localparam int NUM_COLS  = 9;
  localparam int MAX_CASES = 32;
  localparam int CLK_HALF  = 50;
  // upper stamp bits set so the 56 bit truncation is visible
  localparam tgen_pkg::stamp_t STAMP_START = 64'h0123_4567_89ab_cd00;

  logic                S_AXI_ACLK;
  logic                S_AXI_ARESETN;
  tgen_pkg::word_t     cfg_ipg;
  tgen_pkg::word_t     cfg_frame_count;
  tgen_pkg::word_t     cfg_word_count;
  tgen_pkg::word_t     cfg_last_strb;
  logic                ext_gate_ctrl;
  logic                ext_rst_count;
  logic                ext_switch_lane0_on;
  logic                ext_switch_lane1_on;
  logic                ext_switch_lane0_done;
  logic                ext_switch_lane1_done;
  tgen_pkg::stamp_t    stamp_counter;
  tgen_pkg::tdata_t    m_axis_tdata;
  tgen_pkg::tstrb_t    m_axis_tstrb;
  tgen_pkg::tuser_t    m_axis_tuser;
  logic                m_axis_tvalid;
  logic                m_axis_tready;
  logic                m_axis_tlast;
  tgen_pkg::tdata_t    s_axis_tdata;
  logic                s_axis_tvalid;
  logic                s_axis_tlast;
  logic                s_axis_tready;
  tgen_pkg::word_t     arr_seq_num;
  tgen_pkg::word_t     exp_seq_num;
  tgen_pkg::stamp_t    rx_stamp_start;
  tgen_pkg::stamp_t    rx_stamp_stop;
  tgen_pkg::sw_stamp_t sw_ln0_start;
  tgen_pkg::sw_stamp_t sw_ln0_stop;
  tgen_pkg::sw_stamp_t sw_ln1_start;
  tgen_pkg::sw_stamp_t sw_ln1_stop;

  // case table as loaded with unused entries left at x
  tgen_pkg::word_t case_mem [0:NUM_COLS*MAX_CASES-1];
  int n_cases;
  int budget_cycles;
  int value_errors;
  int other_errors;

  // current case
  tgen_pkg::word_t case_words;
  tgen_pkg::word_t case_strb;
  tgen_pkg::word_t ready_density;
  tgen_pkg::word_t lcg_state;

  // reference model of the stream and the results
  tgen_pkg::word_t     beat_idx;
  tgen_pkg::word_t     seq_idx;
  tgen_pkg::word_t     frames_seen;
  logic                rx_due;
  tgen_pkg::word_t     rx_seq;
  tgen_pkg::stamp_t    rx_stamp;
  // ln0 on, ln1 on, ln0 done, ln1 done
  tgen_pkg::sw_stamp_t exp_sw [4];

  simple_tx UUT (
    .S_AXI_ACLK            (S_AXI_ACLK),
    .S_AXI_ARESETN         (S_AXI_ARESETN),
    .cfg_ipg               (cfg_ipg),
    .cfg_frame_count       (cfg_frame_count),
    .cfg_word_count        (cfg_word_count),
    .cfg_last_strb         (cfg_last_strb),
    .ext_gate_ctrl         (ext_gate_ctrl),
    .ext_rst_count         (ext_rst_count),
    .ext_switch_lane0_on   (ext_switch_lane0_on),
    .ext_switch_lane1_on   (ext_switch_lane1_on),
    .ext_switch_lane0_done (ext_switch_lane0_done),
    .ext_switch_lane1_done (ext_switch_lane1_done),
    .stamp_counter         (stamp_counter),
    .m_axis_tdata          (m_axis_tdata),
    .m_axis_tstrb          (m_axis_tstrb),
    .m_axis_tuser          (m_axis_tuser),
    .m_axis_tvalid         (m_axis_tvalid),
    .m_axis_tready         (m_axis_tready),
    .m_axis_tlast          (m_axis_tlast),
    .s_axis_tdata          (s_axis_tdata),
    .s_axis_tvalid         (s_axis_tvalid),
    .s_axis_tlast          (s_axis_tlast),
    .s_axis_tready         (s_axis_tready),
    .arr_seq_num           (arr_seq_num),
    .exp_seq_num           (exp_seq_num),
    .rx_stamp_start        (rx_stamp_start),
    .rx_stamp_stop         (rx_stamp_stop),
    .sw_ln0_start          (sw_ln0_start),
    .sw_ln0_stop           (sw_ln0_stop),
    .sw_ln1_start          (sw_ln1_start),
    .sw_ln1_stop           (sw_ln1_stop)
  );

  // loopback where the slave side only sees beats that actually transfer
  assign s_axis_tdata  = m_axis_tdata;
  assign s_axis_tlast  = m_axis_tlast;
  assign s_axis_tvalid = m_axis_tvalid && m_axis_tready;

  always #CLK_HALF S_AXI_ACLK = ~S_AXI_ACLK;

  // free-running stamp source
  always @(posedge S_AXI_ACLK) begin
    stamp_counter <= stamp_counter + 64'd1;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic tgen_pkg::word_t lcg_next(input tgen_pkg::word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // last cycle after the gate that carries a switch pulse
  function automatic tgen_pkg::word_t latest_pulse(input int base);
    tgen_pkg::word_t last;
    last = 0;
    for (int j = 5; j < NUM_COLS; j++) begin
      if (case_mem[base+j] > last) begin
        last = case_mem[base+j];
      end
    end
    return last;
  endfunction

  // frames x (beats + gap + 4) x 4 per case plus switch tails and fixed overhead
  function automatic int budget_from_cases();
    int total;
    int base;
    total = 200;
    for (int k = 0; k < n_cases; k++) begin
      base  = NUM_COLS * k;
      total = total + case_mem[base+1] * (case_mem[base+2] + 5 + case_mem[base]) * 4;
      total = total + latest_pulse(base) + case_mem[base] + 40;
    end
    return total;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_tdata(input string name, input tgen_pkg::tdata_t got,
                             input tgen_pkg::tdata_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_tstrb(input string name, input tgen_pkg::tstrb_t got,
                             input tgen_pkg::tstrb_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_tuser(input string name, input tgen_pkg::tuser_t got,
                             input tgen_pkg::tuser_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_word(input string name, input tgen_pkg::word_t got,
                            input tgen_pkg::word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_stamp(input string name, input tgen_pkg::stamp_t got,
                             input tgen_pkg::stamp_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_sw_stamp(input string name, input tgen_pkg::sw_stamp_t got,
                                input tgen_pkg::sw_stamp_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s at %0t got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_switch_stamps();
    check_sw_stamp("sw_ln0_start", sw_ln0_start, exp_sw[0]);
    check_sw_stamp("sw_ln1_start", sw_ln1_start, exp_sw[1]);
    check_sw_stamp("sw_ln0_stop", sw_ln0_stop, exp_sw[2]);
    check_sw_stamp("sw_ln1_stop", sw_ln1_stop, exp_sw[3]);
  endtask

  // every statistic back at 0
  task automatic check_results_clear();
    check_word("arr_seq_num", arr_seq_num, '0);
    check_word("exp_seq_num", exp_seq_num, '0);
    check_stamp("rx_stamp_start", rx_stamp_start, '0);
    check_stamp("rx_stamp_stop", rx_stamp_stop, '0);
    check_sw_stamp("sw_ln0_start", sw_ln0_start, '0);
    check_sw_stamp("sw_ln1_start", sw_ln1_start, '0);
    check_sw_stamp("sw_ln0_stop", sw_ln0_stop, '0);
    check_sw_stamp("sw_ln1_stop", sw_ln1_stop, '0);
  endtask

  ////////////////////////////////////////
  // stream model
  ////////////////////////////////////////

  // one beat that transfers on the coming rising edge
  task automatic check_beat();
    tgen_pkg::tdata_t exp_data;
    tgen_pkg::tstrb_t exp_strb;
    tgen_pkg::tuser_t exp_user;
    tgen_pkg::word_t  n_beats;
    logic             exp_last;
    // a nonzero last strobe adds a partial tail beat
    n_beats  = (case_strb != '0) ? case_words + 32'd1 : case_words;
    exp_last = (beat_idx == n_beats - 32'd1);
    exp_strb = (exp_last && case_strb != '0) ? case_strb : tgen_pkg::FULL_STRB;
    exp_user = '0;
    exp_data = {tgen_pkg::TSTRB_W{tgen_pkg::FILLER_BYTE}};
    if (beat_idx == 0) begin
      exp_data = tgen_pkg::HEADER_TDATA;
      exp_user = tgen_pkg::HEADER_TUSER;
    end else if (beat_idx == 1) begin
      // tag, sequence and stamp laid over the filler
      exp_data[15:0]                          = tgen_pkg::PAYLOAD_TAG;
      exp_data[tgen_pkg::SEQ_LSB +: 32]       = seq_idx;
      exp_data[tgen_pkg::STAMP_LSB +: 64]     = stamp_counter;
      rx_seq   = seq_idx;
      rx_stamp = stamp_counter;
      rx_due   = 1'b1;
    end
    check_tdata("m_axis_tdata", m_axis_tdata, exp_data);
    check_tstrb("m_axis_tstrb", m_axis_tstrb, exp_strb);
    check_tuser("m_axis_tuser", m_axis_tuser, exp_user);
    check_bit("m_axis_tlast", m_axis_tlast, exp_last);
    if (exp_last) begin
      beat_idx    = 0;
      seq_idx     = seq_idx + 32'd1;
      frames_seen = frames_seen + 32'd1;
    end else begin
      beat_idx = beat_idx + 32'd1;
    end
  endtask

  // inputs and outputs are settled on the falling edge
  always @(negedge S_AXI_ACLK) begin
    // results from the second beat accepted on the last rising edge
    if (rx_due) begin
      check_word("arr_seq_num", arr_seq_num, rx_seq);
      check_word("exp_seq_num", exp_seq_num, rx_seq);
      check_stamp("rx_stamp_start", rx_stamp_start, rx_stamp);
      check_stamp("rx_stamp_stop", rx_stamp_stop, rx_stamp);
      rx_due = 1'b0;
    end
    // a pulse seen now is sampled on the next rising edge
    if (ext_switch_lane0_on) begin
      exp_sw[0] = stamp_counter[tgen_pkg::SW_STAMP_W-1:0];
    end
    if (ext_switch_lane1_on) begin
      exp_sw[1] = stamp_counter[tgen_pkg::SW_STAMP_W-1:0];
    end
    if (ext_switch_lane0_done) begin
      exp_sw[2] = stamp_counter[tgen_pkg::SW_STAMP_W-1:0];
    end
    if (ext_switch_lane1_done) begin
      exp_sw[3] = stamp_counter[tgen_pkg::SW_STAMP_W-1:0];
    end
    if (S_AXI_ARESETN && m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
      check_beat();
    end
  end

  // back-pressure with the density counted out of 16
  always @(posedge S_AXI_ACLK) begin
    lcg_state = lcg_next(lcg_state);
    if (!S_AXI_ARESETN) begin
      m_axis_tready <= 1'b0;
    end else begin
      m_axis_tready <= ({28'd0, lcg_state[27:24]} < ready_density);
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  task automatic run_case(input int k);
    int              base;
    int              cyc;
    tgen_pkg::word_t last_pulse;
    base       = NUM_COLS * k;
    last_pulse = latest_pulse(base);
    // counter reset with the new configuration while tx is idle
    @(posedge S_AXI_ACLK);
    cfg_ipg         <= case_mem[base];
    cfg_frame_count <= case_mem[base+1];
    cfg_word_count  <= case_mem[base+2];
    cfg_last_strb   <= case_mem[base+3];
    ext_rst_count   <= 1'b1;
    @(posedge S_AXI_ACLK);
    ext_rst_count <= 1'b0;
    // one cycle in the register stage and one more for the synchronous clear
    repeat (3) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    check_results_clear();
    @(posedge S_AXI_ACLK);
    case_words    = case_mem[base+2];
    case_strb     = case_mem[base+3];
    ready_density <= case_mem[base+4];
    beat_idx      = 0;
    seq_idx       = 0;
    frames_seen   = 0;
    rx_due        = 1'b0;
    for (int j = 0; j < 4; j++) begin
      exp_sw[j] = '0;
    end
    ext_gate_ctrl <= 1'b1;
    cyc = 0;
    while (frames_seen < case_mem[base+1] || cyc <= last_pulse) begin
      @(posedge S_AXI_ACLK);
      cyc++;
      ext_gate_ctrl         <= 1'b0;
      ext_switch_lane0_on   <= (cyc == case_mem[base+5]);
      ext_switch_lane1_on   <= (cyc == case_mem[base+6]);
      ext_switch_lane0_done <= (cyc == case_mem[base+7]);
      ext_switch_lane1_done <= (cyc == case_mem[base+8]);
    end
    // long enough for one more frame to start if the burst overran
    repeat (case_mem[base] + 6) @(negedge S_AXI_ACLK);
    if (frames_seen != case_mem[base+1] || beat_idx != 0) begin
      other_errors++;
      $display("case %0d sent %0d frames plus %0d stray beats, expected %0d frames",
               k, frames_seen, beat_idx, case_mem[base+1]);
    end
    // an extra frame held back by ready still shows up as a valid beat
    if (m_axis_tvalid !== 1'b0) begin
      other_errors++;
      $display("case %0d still offers a beat after the burst should have ended", k);
    end
    check_switch_stamps();
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    S_AXI_ACLK            = 1'b0;
    S_AXI_ARESETN         = 1'b0;
    cfg_ipg               = tgen_pkg::IPG_DEFAULT;
    cfg_frame_count       = tgen_pkg::FRAMES_DEFAULT;
    cfg_word_count        = tgen_pkg::WORDS_DEFAULT;
    cfg_last_strb         = tgen_pkg::LAST_STRB_DEFAULT;
    ext_gate_ctrl         = 1'b0;
    ext_rst_count         = 1'b0;
    ext_switch_lane0_on   = 1'b0;
    ext_switch_lane1_on   = 1'b0;
    ext_switch_lane0_done = 1'b0;
    ext_switch_lane1_done = 1'b0;
    stamp_counter         = STAMP_START;
    m_axis_tready         = 1'b0;
    lcg_state             = 32'd85432;
    ready_density         = 32'd16;
    value_errors          = 0;
    other_errors          = 0;
    budget_cycles         = 0;
    case_words            = tgen_pkg::WORDS_DEFAULT;
    case_strb             = tgen_pkg::LAST_STRB_DEFAULT;
    beat_idx              = 0;
    seq_idx               = 0;
    frames_seen           = 0;
    rx_due                = 1'b0;
    rx_seq                = '0;
    rx_stamp              = '0;
    for (int j = 0; j < 4; j++) begin
      exp_sw[j] = '0;
    end
    $readmemh("tgen_testdata.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && !$isunknown(case_mem[NUM_COLS*n_cases])) begin
      n_cases++;
    end
    budget_cycles = budget_from_cases();
    repeat (5) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    repeat (2) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    // state straight out of reset
    check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_bit("m_axis_tlast", m_axis_tlast, 1'b0);
    check_bit("s_axis_tready", s_axis_tready, 1'b1);
    check_results_clear();
    if (n_cases == 0) begin
      other_errors++;
      $display("no test cases could be read from tgen_testdata.txt");
    end else begin
      for (int k = 0; k < n_cases; k++) begin
        run_case(k);
      end
    end
    finish_run();
  end

  // watchdog sized from the case table
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge S_AXI_ACLK);
    other_errors++;
    $display("timeout, the run was still busy after %0d cycles", budget_cycles);
    finish_run();
  end

endmodule

// File: tgen_config_regs.sv
`timescale 1ns/1ps

module tgen_config_regs (
  input  logic            S_AXI_ACLK,
  input  logic            S_AXI_ARESETN,
  input  tgen_pkg::word_t cfg_ipg,
  input  tgen_pkg::word_t cfg_frame_count,
  input  tgen_pkg::word_t cfg_word_count,
  input  tgen_pkg::word_t cfg_last_strb,
  input  logic            ext_gate_ctrl,
  input  logic            ext_rst_count,
  output tgen_pkg::word_t ipg_value,
  output tgen_pkg::word_t frame_value,
  output tgen_pkg::word_t words_value,
  output tgen_pkg::word_t last_strb_value,
  output logic            gate_pulse,
  output logic            cnt_rst
);

  // sample everything once per cycle
  // cnt_rst comes up high so the downstream blocks are cleared while in reset
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      ipg_value       <= tgen_pkg::IPG_DEFAULT;
      frame_value     <= tgen_pkg::FRAMES_DEFAULT;
      words_value     <= tgen_pkg::WORDS_DEFAULT;
      last_strb_value <= tgen_pkg::LAST_STRB_DEFAULT;
      gate_pulse      <= 1'b0;
      cnt_rst         <= 1'b1;
    end else begin
      ipg_value       <= cfg_ipg;
      frame_value     <= cfg_frame_count;
      words_value     <= cfg_word_count;
      last_strb_value <= cfg_last_strb;
      // one cycle late, the tx fsm sees the gate here
      gate_pulse      <= ext_gate_ctrl;
      cnt_rst         <= ext_rst_count;
    end
  end

endmodule

// File: tgen_pkg.sv
package tgen_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned WORD_W     = 32;
  localparam int unsigned STAMP_W    = 64;
  localparam int unsigned SW_STAMP_W = 56;
  localparam int unsigned TDATA_W    = 256;
  localparam int unsigned TSTRB_W    = TDATA_W / 8;
  localparam int unsigned TUSER_W    = 128;

  // config words and sequence numbers
  typedef logic [WORD_W-1:0]     word_t;
  // free-running timestamp as seen on the stamp input
  typedef logic [STAMP_W-1:0]    stamp_t;
  // the switch only keeps the low 56 bits
  typedef logic [SW_STAMP_W-1:0] sw_stamp_t;
  typedef logic [TDATA_W-1:0]    tdata_t;
  typedef logic [TSTRB_W-1:0]    tstrb_t;
  typedef logic [TUSER_W-1:0]    tuser_t;

  // tx fsm, gate waits for a trigger, gap spaces frames apart
  typedef enum logic [1:0] {gate, gap, first_word, remainder} tx_state_e;
  // rx fsm, skips the header and decodes the second beat
  typedef enum logic [1:0] {wait_arrival, head_detect, second_detect} rx_state_e;

  ////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////

  // first beat, little endian so the ethernet dest address sits in the low bytes
  localparam tdata_t HEADER_TDATA = {
    8'h00,                // tail of ip dest
    32'h0000_0700,        // ip dest / src split across the beat
    16'h0900,
    32'h0000_0600,        // ttl, protocol, checksum
    8'h01,
    32'h0000_0000,        // id, flags, fragment offset
    16'h0200,             // version/ihl, dscp
    16'h0888,             // ethertype
    48'hbbbb_bbbb_bbbb,   // ethernet src
    48'haaaa_aaaa_aaaa    // ethernet dest
  };

  // metadata: dst port 0x05, src port 0x01, length 0x40
  localparam tuser_t HEADER_TUSER = {96'h0, 8'h05, 8'h01, 16'h0040};

  localparam logic [7:0]  FILLER_BYTE = 8'hC3;
  localparam logic [15:0] PAYLOAD_TAG = 16'h0007;

  // field positions inside the second beat
  localparam int unsigned SEQ_LSB   = 16;
  localparam int unsigned STAMP_LSB = 48;
  // filler bytes above the timestamp
  localparam int unsigned PAD_BYTES = (TDATA_W - STAMP_LSB - STAMP_W) / 8;

  localparam tstrb_t FULL_STRB = '1;

  // number of switch events that get a timestamp
  localparam int unsigned NUM_SW_EVENTS = 4;

  ////////////////////////////////////////
  // reset defaults
  ////////////////////////////////////////

  localparam word_t IPG_DEFAULT       = 32'd2;
  localparam word_t FRAMES_DEFAULT    = 32'd0;
  localparam word_t WORDS_DEFAULT     = 32'd2;
  localparam word_t LAST_STRB_DEFAULT = 32'h0000_3FFF;

endpackage

// File: tgen_rx_analyzer.sv
`timescale 1ns/1ps

module tgen_rx_analyzer (
  input  logic              S_AXI_ACLK,
  input  logic              cnt_rst,
  input  tgen_pkg::tdata_t  s_axis_tdata,
  input  logic              s_axis_tvalid,
  input  logic              s_axis_tlast,
  input  tgen_pkg::stamp_t  stamp_counter,
  output logic              s_axis_tready,
  output tgen_pkg::word_t   arr_seq_num,
  output tgen_pkg::word_t   exp_seq_num,
  output tgen_pkg::stamp_t  rx_stamp_start,
  output tgen_pkg::stamp_t  rx_stamp_stop
);

  tgen_pkg::rx_state_e state;
  // frames decoded since the last counter reset
  tgen_pkg::word_t rx_count;
  logic beat_acc;

  // the analyzer never pushes back
  assign s_axis_tready = 1'b1;
  assign beat_acc      = s_axis_tvalid && s_axis_tready;

  always_ff @(posedge S_AXI_ACLK) begin
    if (cnt_rst) begin
      state          <= tgen_pkg::wait_arrival;
      rx_count       <= '0;
      arr_seq_num    <= '0;
      exp_seq_num    <= '0;
      rx_stamp_start <= '0;
      rx_stamp_stop  <= '0;
    end else begin
      case (state)
        tgen_pkg::wait_arrival: begin
          // header beat, nothing to decode
          if (beat_acc && !s_axis_tlast) begin
            state <= tgen_pkg::head_detect;
          end
        end
        tgen_pkg::head_detect: begin
          if (beat_acc) begin
            arr_seq_num    <= s_axis_tdata[tgen_pkg::SEQ_LSB +: tgen_pkg::WORD_W];
            exp_seq_num    <= rx_count;
            rx_stamp_start <= s_axis_tdata[tgen_pkg::STAMP_LSB +: tgen_pkg::STAMP_W];
            rx_stamp_stop  <= stamp_counter;
            rx_count       <= rx_count + 32'd1;
            // a two beat frame ends right here
            state <= s_axis_tlast ? tgen_pkg::wait_arrival : tgen_pkg::second_detect;
          end
        end
        tgen_pkg::second_detect: begin
          // drain filler beats
          if (beat_acc && s_axis_tlast) begin
            state <= tgen_pkg::wait_arrival;
          end
        end
        default: state <= tgen_pkg::wait_arrival;
      endcase
    end
  end

endmodule

// File: tgen_switch_stamp.sv
`timescale 1ns/1ps

module tgen_switch_stamp (
  input  logic                S_AXI_ACLK,
  input  logic                cnt_rst,
  input  logic                ext_switch_lane0_on,
  input  logic                ext_switch_lane1_on,
  input  logic                ext_switch_lane0_done,
  input  logic                ext_switch_lane1_done,
  input  tgen_pkg::stamp_t    stamp_counter,
  output tgen_pkg::sw_stamp_t sw_ln0_start,
  output tgen_pkg::sw_stamp_t sw_ln0_stop,
  output tgen_pkg::sw_stamp_t sw_ln1_start,
  output tgen_pkg::sw_stamp_t sw_ln1_stop
);

  // event order: ln0 on, ln1 on, ln0 done, ln1 done
  logic [tgen_pkg::NUM_SW_EVENTS-1:0] pulse;
  tgen_pkg::sw_stamp_t stamp_q [tgen_pkg::NUM_SW_EVENTS];

  assign pulse = {ext_switch_lane1_done, ext_switch_lane0_done,
                  ext_switch_lane1_on, ext_switch_lane0_on};

  // each slot grabs the low bits of the counter on its pulse and holds otherwise
  always_ff @(posedge S_AXI_ACLK) begin
    for (int i = 0; i < tgen_pkg::NUM_SW_EVENTS; i++) begin
      if (cnt_rst) begin
        stamp_q[i] <= '0;
      end else if (pulse[i]) begin
        stamp_q[i] <= stamp_counter[tgen_pkg::SW_STAMP_W-1:0];
      end
    end
  end

  assign sw_ln0_start = stamp_q[0];
  assign sw_ln1_start = stamp_q[1];
  assign sw_ln0_stop  = stamp_q[2];
  assign sw_ln1_stop  = stamp_q[3];

endmodule

// File: tgen_testdata.txt
// ipg frames words last_strb ready_density(of 16) ln0_on ln1_on ln0_done ln1_done
// all hex, switch columns are cycles after the gate pulse, 0 means no pulse
2 3 2 3fff 10 0 0 0 0
0 2 2 0 10 3 5 9 c
1 4 3 ffffffff 10 1 2 3 4
5 3 4 1 c 0 7 0 11
3 5 2 ff 8 4 4 20 21
4 0 2 3fff 10 6 0 a 0
2 6 6 0 a 10 13 30 31
1 3 8 80000000 9 2 0 0 15
7 2 5 f0 10 0 1 0 1
2 8 2 1 b 8 9 a b
0 4 3 0 8 0 0 0 0
3 3 a ffff 10 11 22 33 44
1 10 2 3 e 5 6 7 8

// File: tgen_tx_fsm.sv
`timescale 1ns/1ps

module tgen_tx_fsm (
  input  logic              S_AXI_ACLK,
  input  logic              cnt_rst,
  input  logic              gate_pulse,
  input  tgen_pkg::word_t   ipg_value,
  input  tgen_pkg::word_t   frame_value,
  input  tgen_pkg::word_t   words_value,
  input  tgen_pkg::word_t   last_strb_value,
  input  tgen_pkg::stamp_t  stamp_counter,
  output tgen_pkg::tdata_t  m_axis_tdata,
  output tgen_pkg::tstrb_t  m_axis_tstrb,
  output tgen_pkg::tuser_t  m_axis_tuser,
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic              m_axis_tlast
);

  tgen_pkg::tx_state_e state;
  tgen_pkg::tx_state_e state_next;
  // state of the last beat that was accepted, or of the last idle cycle
  tgen_pkg::tx_state_e state_prev;

  tgen_pkg::word_t gap_cnt;
  tgen_pkg::word_t frames_left;
  // words still to send after the current beat
  tgen_pkg::word_t words_left;
  tgen_pkg::word_t seq_cnt;

  logic last_strb_zero;
  logic last_beat;
  logic beat_xfer;

  assign last_strb_zero = (last_strb_value == '0);
  // ends on the partial word, or on the last full word if there is no partial tail
  assign last_beat = (words_left == '0) || ((words_left == 32'd1) && last_strb_zero);
  assign beat_xfer = m_axis_tvalid && m_axis_tready;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      tgen_pkg::gate: begin
        if (gate_pulse) begin
          state_next = tgen_pkg::gap;
        end
      end
      tgen_pkg::gap: begin
        // a gap of 0 or 1 still takes one cycle
        if (gap_cnt <= 32'd1) begin
          state_next = (frames_left == '0) ? tgen_pkg::gate : tgen_pkg::first_word;
        end
      end
      tgen_pkg::first_word: begin
        if (m_axis_tready) begin
          state_next = tgen_pkg::remainder;
        end
      end
      tgen_pkg::remainder: begin
        if (m_axis_tready && last_beat) begin
          state_next = tgen_pkg::gap;
        end
      end
      default: state_next = tgen_pkg::gate;
    endcase
  end

  ////////////////////////////////////////
  // state and counters
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (cnt_rst) begin
      state       <= tgen_pkg::gate;
      state_prev  <= tgen_pkg::gate;
      gap_cnt     <= tgen_pkg::IPG_DEFAULT;
      frames_left <= tgen_pkg::FRAMES_DEFAULT;
      words_left  <= tgen_pkg::WORDS_DEFAULT;
      seq_cnt     <= '0;
    end else begin
      state <= state_next;
      // frozen while a beat stalls, so a stalled second beat keeps its payload
      if (!m_axis_tvalid || m_axis_tready) begin
        state_prev <= state;
      end
      case (state)
        tgen_pkg::gate: begin
          if (gate_pulse) begin
            frames_left <= frame_value;
            words_left  <= words_value;
            gap_cnt     <= ipg_value;
          end
        end
        tgen_pkg::gap: begin
          if (gap_cnt > 32'd1) begin
            gap_cnt <= gap_cnt - 32'd1;
          end
        end
        tgen_pkg::first_word: begin
          if (beat_xfer) begin
            words_left <= words_left - 32'd1;
          end
        end
        tgen_pkg::remainder: begin
          if (beat_xfer) begin
            if (last_beat) begin
              // frame done, rearm for the next one
              words_left  <= words_value;
              frames_left <= frames_left - 32'd1;
              gap_cnt     <= ipg_value;
              seq_cnt     <= seq_cnt + 32'd1;
            end else begin
              words_left <= words_left - 32'd1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // stream outputs, decoded from state
  ////////////////////////////////////////

  always_comb begin
    m_axis_tvalid = 1'b0;
    m_axis_tlast  = 1'b0;
    m_axis_tdata  = '0;
    m_axis_tstrb  = '0;
    m_axis_tuser  = '0;
    case (state)
      tgen_pkg::first_word: begin
        m_axis_tvalid = 1'b1;
        m_axis_tdata  = tgen_pkg::HEADER_TDATA;
        m_axis_tuser  = tgen_pkg::HEADER_TUSER;
        m_axis_tstrb  = tgen_pkg::FULL_STRB;
      end
      tgen_pkg::remainder: begin
        m_axis_tvalid = 1'b1;
        m_axis_tlast  = last_beat;
        // only the partial tail word uses the programmed strobe
        m_axis_tstrb  = (words_left == '0) ? last_strb_value : tgen_pkg::FULL_STRB;
        if (state_prev == tgen_pkg::first_word) begin
          // timestamp follows the live counter until the beat is taken
          m_axis_tdata = {{tgen_pkg::PAD_BYTES{tgen_pkg::FILLER_BYTE}},
                          stamp_counter, seq_cnt, tgen_pkg::PAYLOAD_TAG};
        end else begin
          m_axis_tdata = {tgen_pkg::TSTRB_W{tgen_pkg::FILLER_BYTE}};
        end
      end
      default: ;
    endcase
  end

endmodule
